/* src/rv_pkg.sv */
package rv_pkg;

  // ----------------------------------------------------------
  // Base widths and encodings
  // ----------------------------------------------------------

  // Integer register width for RV32
  localparam int XLEN = 32;

  // Major opcodes handled by the core
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // ALU operations
  // PASS_B forwards operand b untouched, used by LUI
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // ----------------------------------------------------------
  // Stage records
  // ----------------------------------------------------------

  // Decode to operand stage
  typedef struct packed {
    logic            valid;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic            use_rs1;
    logic            use_imm;
    logic [XLEN-1:0] imm;
    alu_op_e         op;
  } decoded_t;

  // Operand stage to ALU
  typedef struct packed {
    logic            valid;
    logic [4:0]      rd;
    alu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } operand_t;

  // Result record, also used for forwarding
  typedef struct packed {
    logic            valid;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
  } writeback_t;

endpackage

/* src/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode #(
  parameter int REG_COUNT = 32
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_valid,
  input  logic [31:0]      i_instr,
  output rv_pkg::decoded_t o_dec,
  output logic             o_illegal
);

  import rv_pkg::*;

  // funct7 values seen on OP and shift encodings
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // ----------------------------------------------------------
  // Instruction fields
  // ----------------------------------------------------------

  logic [6:0]      opcode;
  logic [4:0]      rd;
  logic [2:0]      funct3;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;

  assign opcode = i_instr[6:0];
  assign rd     = i_instr[11:7];
  assign funct3 = i_instr[14:12];
  assign rs1    = i_instr[19:15];
  assign rs2    = i_instr[24:20];
  assign funct7 = i_instr[31:25];

  // Sign-extended I immediate
  assign imm_i = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
  // U immediate, upper 20 bits
  assign imm_u = {i_instr[31:12], 12'b0};

  // ----------------------------------------------------------
  // Decode
  // ----------------------------------------------------------

  decoded_t dec;
  logic     use_rs2;
  logic     bad_enc;
  logic     bad_reg;

  always_comb begin
    dec         = '0;
    dec.rd      = rd;
    dec.rs1     = rs1;
    dec.rs2     = rs2;
    dec.op      = ALU_ADD;
    use_rs2     = 1'b0;
    bad_enc     = 1'b0;

    case (opcode)
      OPC_OP: begin
        dec.use_rs1 = 1'b1;
        use_rs2     = 1'b1;
        case (funct3)
          3'd0: dec.op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
          3'd1: dec.op = ALU_SLL;
          3'd2: dec.op = ALU_SLT;
          3'd3: dec.op = ALU_SLTU;
          3'd4: dec.op = ALU_XOR;
          3'd5: dec.op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
          3'd6: dec.op = ALU_OR;
          default: dec.op = ALU_AND;
        endcase
        // Only ADD/SUB and SRL/SRA accept the alternate funct7
        if (funct3 == 3'd0 || funct3 == 3'd5) begin
          bad_enc = (funct7 != F7_BASE) && (funct7 != F7_ALT);
        end else begin
          bad_enc = (funct7 != F7_BASE);
        end
      end

      OPC_OP_IMM: begin
        dec.use_rs1 = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = imm_i;
        case (funct3)
          3'd0: dec.op = ALU_ADD;
          3'd1: dec.op = ALU_SLL;
          3'd2: dec.op = ALU_SLT;
          3'd3: dec.op = ALU_SLTU;
          3'd4: dec.op = ALU_XOR;
          3'd5: dec.op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
          3'd6: dec.op = ALU_OR;
          default: dec.op = ALU_AND;
        endcase
        // Shift immediates carry funct7 in the upper bits
        if (funct3 == 3'd1) begin
          bad_enc = (funct7 != F7_BASE);
        end else if (funct3 == 3'd5) begin
          bad_enc = (funct7 != F7_BASE) && (funct7 != F7_ALT);
        end
      end

      OPC_LUI: begin
        dec.use_imm = 1'b1;
        dec.imm     = imm_u;
        dec.op      = ALU_PASS_B;
      end

      default: bad_enc = 1'b1;
    endcase

    // Register indices beyond the implemented file (RV32E)
    bad_reg = (int'(rd) >= REG_COUNT)
            || (dec.use_rs1 && int'(rs1) >= REG_COUNT)
            || (use_rs2 && int'(rs2) >= REG_COUNT);

    dec.valid = i_valid && !bad_enc && !bad_reg;
  end

  // ----------------------------------------------------------
  // Stage register
  // ----------------------------------------------------------

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_dec     <= '0;
      o_illegal <= 1'b0;
    end else begin
      o_dec     <= dec;
      // One-cycle flag, the micro-op itself is dropped
      o_illegal <= i_valid && (bad_enc || bad_reg);
    end
  end

endmodule

/* src/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile #(
  parameter int REG_COUNT = 32
) (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic [4:0]              i_rs1,
  input  logic [4:0]              i_rs2,
  output logic [rv_pkg::XLEN-1:0] o_rdata1,
  output logic [rv_pkg::XLEN-1:0] o_rdata2,
  input  rv_pkg::writeback_t      i_wb
);

  import rv_pkg::*;

  // Register storage, entry 0 stays at zero
  logic [XLEN-1:0] regs [REG_COUNT];

  logic rd1_ok;
  logic rd2_ok;
  logic wr_en;

  // ----------------------------------------------------------
  // Read ports
  // ----------------------------------------------------------

  // x0 and unimplemented indices read as zero
  assign rd1_ok = (i_rs1 != 5'd0) && (int'(i_rs1) < REG_COUNT);
  assign rd2_ok = (i_rs2 != 5'd0) && (int'(i_rs2) < REG_COUNT);

  // Combinational reads
  assign o_rdata1 = rd1_ok ? regs[i_rs1] : '0;
  assign o_rdata2 = rd2_ok ? regs[i_rs2] : '0;

  // ----------------------------------------------------------
  // Write port
  // ----------------------------------------------------------

  // Writes to x0 are dropped here
  assign wr_en = i_wb.valid && (i_wb.rd != 5'd0) && (int'(i_wb.rd) < REG_COUNT);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      // Whole file cleared
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[i_wb.rd] <= i_wb.data;
    end
  end

endmodule

/* src/rv_operand.sv */
`timescale 1ns/1ps

module rv_operand (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  rv_pkg::decoded_t        i_dec,
  output logic [4:0]              o_rs1,
  output logic [4:0]              o_rs2,
  input  logic [rv_pkg::XLEN-1:0] i_rdata1,
  input  logic [rv_pkg::XLEN-1:0] i_rdata2,
  input  rv_pkg::writeback_t      i_fwd,
  input  rv_pkg::writeback_t      i_wb,
  output rv_pkg::operand_t        o_opr
);

  import rv_pkg::*;

  // ----------------------------------------------------------
  // Forwarding
  // ----------------------------------------------------------

  // Youngest matching producer wins
  // ALU result first, then writeback, then the file
  function automatic logic [XLEN-1:0] pick_src(
    input logic [4:0]      idx,
    input logic [XLEN-1:0] rdata,
    input writeback_t      fwd,
    input writeback_t      wb
  );
    logic [XLEN-1:0] val;
    if (idx == 5'd0) begin
      val = '0;
    end else if (fwd.valid && fwd.rd == idx) begin
      val = fwd.data;
    end else if (wb.valid && wb.rd == idx) begin
      val = wb.data;
    end else begin
      val = rdata;
    end
    return val;
  endfunction

  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  operand_t        opr;

  // Register file addresses straight from the micro-op
  assign o_rs1 = i_dec.rs1;
  assign o_rs2 = i_dec.rs2;

  assign src1 = pick_src(i_dec.rs1, i_rdata1, i_fwd, i_wb);
  assign src2 = pick_src(i_dec.rs2, i_rdata2, i_fwd, i_wb);

  // ----------------------------------------------------------
  // Operand bundle
  // ----------------------------------------------------------

  always_comb begin
    opr.valid = i_dec.valid;
    opr.rd    = i_dec.rd;
    opr.op    = i_dec.op;
    // LUI has no rs1
    opr.a     = i_dec.use_rs1 ? src1 : '0;
    // Immediate replaces rs2 for OP-IMM and LUI
    opr.b     = i_dec.use_imm ? i_dec.imm : src2;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_opr <= '0;
    end else begin
      o_opr <= opr;
    end
  end

endmodule

/* src/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  rv_pkg::operand_t   i_opr,
  output rv_pkg::writeback_t o_fwd,
  output rv_pkg::writeback_t o_wb
);

  import rv_pkg::*;

  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic [4:0]      shamt;
  logic            lt_s;
  logic            lt_u;
  logic [XLEN-1:0] result;

  // ----------------------------------------------------------
  // Execute
  // ----------------------------------------------------------

  assign a     = i_opr.a;
  assign b     = i_opr.b;
  // Shift amount from low bits of b
  assign shamt = b[4:0];

  // Signed and unsigned compares
  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  always_comb begin
    case (i_opr.op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU:   result = {{(XLEN-1){1'b0}}, lt_u};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  // ----------------------------------------------------------
  // Result outputs
  // ----------------------------------------------------------

  // Same-cycle result for the instruction behind
  always_comb begin
    o_fwd.valid = i_opr.valid;
    o_fwd.rd    = i_opr.rd;
    o_fwd.data  = result;
  end

  // Writeback register
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb <= '0;
    end else begin
      o_wb <= o_fwd;
    end
  end

endmodule

/* src/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top #(
  parameter int REG_COUNT = 32
) (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_valid,
  input  logic [31:0]             i_instr,
  output logic                    o_wb_valid,
  output logic [4:0]              o_wb_rd,
  output logic [rv_pkg::XLEN-1:0] o_wb_data,
  output logic                    o_illegal
);

  import rv_pkg::*;

  // Stage records
  decoded_t        dec;
  operand_t        opr;
  writeback_t      fwd;
  writeback_t      wb;

  // Register file read path
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [XLEN-1:0] rdata1;
  logic [XLEN-1:0] rdata2;

  // ----------------------------------------------------------
  // Pipeline
  // ----------------------------------------------------------

  rv_decode #(
    .REG_COUNT (REG_COUNT)
  ) u_decode (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_valid   (i_valid),
    .i_instr   (i_instr),
    .o_dec     (dec),
    .o_illegal (o_illegal)
  );

  rv_operand u_operand (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_dec    (dec),
    .o_rs1    (rs1),
    .o_rs2    (rs2),
    .i_rdata1 (rdata1),
    .i_rdata2 (rdata2),
    .i_fwd    (fwd),
    .i_wb     (wb),
    .o_opr    (opr)
  );

  rv_alu u_alu (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_opr   (opr),
    .o_fwd   (fwd),
    .o_wb    (wb)
  );

  // Written from the registered writeback
  rv_regfile #(
    .REG_COUNT (REG_COUNT)
  ) u_regfile (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_rs1    (rs1),
    .i_rs2    (rs2),
    .o_rdata1 (rdata1),
    .o_rdata2 (rdata2),
    .i_wb     (wb)
  );

  // Writeback port
  assign o_wb_valid = wb.valid;
  assign o_wb_rd    = wb.rd;
  assign o_wb_data  = wb.data;

endmodule

/* tb/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

  localparam int REG_COUNT     = 32;
  localparam int CLK_PERIOD_NS = 100;
  localparam int RESET_CYCLES  = 4;
  localparam int N_CHAIN       = 24;
  localparam int N_RANDOM      = 200;
  localparam int DRAIN_CYCLES  = 10;
  // Reset, idle, ADD, constants, chain, random, x0 group, illegal group, drain
  localparam int TEST_SLOTS    = RESET_CYCLES + 7 + 62 + N_CHAIN + N_RANDOM + 4 + 12
                               + DRAIN_CYCLES;
  localparam int WATCHDOG_NS   = (TEST_SLOTS + 20) * CLK_PERIOD_NS;

  // Reference outcome of one instruction
  typedef struct packed {
    logic        illegal;
    logic [4:0]  rd;
    logic [31:0] data;
  } ref_result_t;

  // Expected writeback with its arrival cycle
  typedef struct packed {
    int          cyc;
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_exp_t;

  logic        i_clk;
  logic        i_rst_n;
  logic        i_valid;
  logic [31:0] i_instr;
  logic        o_wb_valid;
  logic [4:0]  o_wb_rd;
  logic [31:0] o_wb_data;
  logic        o_illegal;

  logic [31:0] ref_regs [32];
  logic [31:0] rng_state = 32'd58588;
  wb_exp_t     wb_q[$];
  int          ill_q[$];
  int          cycle;
  int          check_count;
  int          value_errors;

  rv_core_top #(
    .REG_COUNT (REG_COUNT)
  ) i_dut (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_valid    (i_valid),
    .i_instr    (i_instr),
    .o_wb_valid (o_wb_valid),
    .o_wb_rd    (o_wb_rd),
    .o_wb_data  (o_wb_data),
    .o_illegal  (o_illegal)
  );

  initial i_clk = 1'b0;
  always #(CLK_PERIOD_NS / 2) i_clk = ~i_clk;

  // Cycle count since reset release
  always @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cycle <= 0;
    end else begin
      cycle <= cycle + 1;
    end
  end

  // ----------------------------------------------------------
  // Encoders and random source
  // ----------------------------------------------------------

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------

  // Integer operation selected by funct3
  // The alt bit picks SUB and SRA
  function automatic logic [31:0] int_op(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // Executes one instruction against ref_regs
  // x0 in ref_regs is never written
  function automatic ref_result_t ref_exec(input logic [31:0] instr);
    ref_result_t res;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    f3  = instr[14:12];
    f7  = instr[31:25];
    a   = ref_regs[instr[19:15]];
    b   = ref_regs[instr[24:20]];
    imm = {{20{instr[31]}}, instr[31:20]};
    res.illegal = 1'b0;
    res.rd      = instr[11:7];
    res.data    = '0;
    case (instr[6:0])
      7'b0110011: begin
        if (f7 == 7'h00) res.data = int_op(f3, 1'b0, a, b);
        else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) res.data = int_op(f3, 1'b1, a, b);
        else res.illegal = 1'b1;
      end
      7'b0010011: begin
        // Shift immediates restrict the upper seven bits
        if (f3 == 3'd1 && f7 != 7'h00) res.illegal = 1'b1;
        else if (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20) res.illegal = 1'b1;
        else res.data = int_op(f3, (f3 == 3'd5) && (f7 == 7'h20), a, imm);
      end
      7'b0110111: res.data = {instr[31:12], 12'h000};
      default: res.illegal = 1'b1;
    endcase
    return res;
  endfunction

  // ----------------------------------------------------------
  // Stimulus helpers for the falling edge
  // ----------------------------------------------------------

  // Accepted at the next rising edge
  // Illegal flag due 1 cycle on and writeback due 3 cycles on
  task automatic issue_instr(input logic [31:0] instr);
    ref_result_t res;
    wb_exp_t     wb;
    res = ref_exec(instr);
    if (res.illegal) begin
      ill_q.push_back(cycle + 1);
    end else begin
      wb.cyc  = cycle + 3;
      wb.rd   = res.rd;
      wb.data = res.data;
      wb_q.push_back(wb);
      if (res.rd != 5'd0) ref_regs[res.rd] = res.data;
    end
    i_valid = 1'b1;
    i_instr = instr;
    @(negedge i_clk);
  endtask

  task automatic idle_cycles(input int n);
    i_valid = 1'b0;
    i_instr = '0;
    repeat (n) @(negedge i_clk);
  endtask

  // LUI plus ADDI builds a 32-bit constant
  // The ADDI reads rd through the distance-1 path
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    issue_instr(lui_word(upper[31:12], rd));
    issue_instr(itype_word(value[11:0], rd, 3'd0, rd));
  endtask

  // Legal OP or OP-IMM on registers lo .. lo+span-1
  task automatic random_alu_instr(input int lo, input int span, output logic [31:0] instr);
    logic [31:0] r;
    logic [31:0] s;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    next_rand(r);
    next_rand(s);
    rd  = 5'(lo + int'(r[7:0]) % span);
    rs1 = 5'(lo + int'(r[15:8]) % span);
    rs2 = 5'(lo + int'(r[23:16]) % span);
    f3  = r[26:24];
    if (r[27]) begin
      instr = rtype_word((r[28] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                         rs2, rs1, f3, rd);
    end else begin
      imm = s[11:0];
      if (f3 == 3'd1) imm[11:5] = 7'h00;
      if (f3 == 3'd5) imm[11:5] = r[28] ? 7'h20 : 7'h00;
      instr = itype_word(imm, rs1, f3, rd);
    end
  endtask

  task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("** Error at %0d ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, got);
    value_errors++;
  endtask

  // ----------------------------------------------------------
  // Comparison on the falling edge where outputs are stable
  // ----------------------------------------------------------

  always @(negedge i_clk) begin : compare_outputs
    wb_exp_t head;
    logic    wb_due;
    logic    ill_due;
    head    = '0;
    wb_due  = 1'b0;
    ill_due = 1'b0;
    if (i_rst_n && cycle > 0) begin
      if (wb_q.size() > 0) begin
        head   = wb_q[0];
        wb_due = (head.cyc == cycle);
      end
      if (ill_q.size() > 0) ill_due = (ill_q[0] == cycle);
      check_count++;
      assert (o_wb_valid === wb_due)
        else report_value("o_wb_valid", 32'(wb_due), 32'(o_wb_valid));
      assert (o_illegal === ill_due)
        else report_value("o_illegal", 32'(ill_due), 32'(o_illegal));
      if (wb_due) begin
        void'(wb_q.pop_front());
        if (o_wb_valid) begin
          assert (o_wb_rd === head.rd)
            else report_value("o_wb_rd", 32'(head.rd), 32'(o_wb_rd));
          assert (o_wb_data === head.data)
            else report_value("o_wb_data", head.data, o_wb_data);
        end
      end
      if (ill_due) void'(ill_q.pop_front());
    end
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------

  initial begin : stimulus
    logic [31:0] instr;
    logic [31:0] value;
    i_rst_n      = 1'b0;
    i_valid      = 1'b0;
    i_instr      = '0;
    check_count  = 0;
    value_errors = 0;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;

    // Quiet after reset
    idle_cycles(6);
    // ADD x3, x1, x2 on cleared registers
    issue_instr(rtype_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));

    // Random constants into x1..x31
    for (int r = 1; r < 32; r++) begin
      next_rand(value);
      load_const(5'(r), value);
    end

    // Dense hazards on x1..x3
    for (int i = 0; i < N_CHAIN; i++) begin
      random_alu_instr(1, 3, instr);
      issue_instr(instr);
    end

    // Whole register file including x0
    for (int i = 0; i < N_RANDOM; i++) begin
      random_alu_instr(0, 32, instr);
      issue_instr(instr);
    end

    // x0 as destination followed by reads at distances 1 to 3
    issue_instr(itype_word(12'h005, 5'd1, 3'd0, 5'd0));
    issue_instr(rtype_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd2));
    issue_instr(rtype_word(7'h00, 5'd1, 5'd0, 3'd0, 5'd3));
    issue_instr(itype_word(12'h000, 5'd0, 3'd6, 5'd4));

    // Illegal encodings each followed by a read of their rd
    issue_instr({12'h004, 5'd1, 3'd2, 5'd5, 7'b0000011});
    issue_instr(rtype_word(7'h00, 5'd0, 5'd5, 3'd0, 5'd5));
    issue_instr(rtype_word(7'h01, 5'd2, 5'd1, 3'd0, 5'd6));
    issue_instr(rtype_word(7'h00, 5'd0, 5'd6, 3'd0, 5'd6));
    issue_instr(rtype_word(7'h20, 5'd2, 5'd1, 3'd1, 5'd7));
    issue_instr(rtype_word(7'h00, 5'd0, 5'd7, 3'd0, 5'd7));
    issue_instr(itype_word({7'h20, 5'd3}, 5'd1, 3'd1, 5'd8));
    issue_instr(rtype_word(7'h00, 5'd0, 5'd8, 3'd0, 5'd8));
    issue_instr(itype_word({7'h10, 5'd3}, 5'd1, 3'd5, 5'd9));
    issue_instr(rtype_word(7'h00, 5'd0, 5'd9, 3'd0, 5'd9));
    issue_instr({20'h00010, 5'd10, 7'b1101111});
    issue_instr(rtype_word(7'h00, 5'd0, 5'd10, 3'd0, 5'd10));

    idle_cycles(DRAIN_CYCLES);

    $display("Checks: %0d, value errors: %0d", check_count, value_errors);
    if (value_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Budget covers every stimulus slot plus slack
  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the test sequence did not finish within %0d ns", WATCHDOG_NS);
    $display("Regression failed");
    $finish;
  end

endmodule

/* files.f */
src/rv_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_operand.sv
src/rv_alu.sv
src/rv_core_top.sv
tb/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# Compile and run the RV32I pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

# Build the simulation binary
verilator --binary --timing --assert -f files.f --top-module tb_rv_core \
  --Mdir "$BUILD_DIR" -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

# Run it and keep the output for the verdict
"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The verdict comes from the log only
if grep -qx "Regression passed" "$LOG"; then
  exit 0
fi
exit 1
